/* rtl/base_pkg.sv */
// Widths are fixed by the platform; memory is 4096 x 16 bits and a game dword spans two words
package base_pkg;

    localparam int BYTE_ADDR_W = 13;  // Download byte address
    localparam int WORD_ADDR_W = 12;  // Memory word address
    localparam int ROM_ADDR_W  = 11;  // Game 32-bit word index
    localparam int MEM_LATENCY = 2;   // Accept to response, in cycles

    typedef enum logic {
        MEM_READ,
        MEM_WRITE
    } mem_op_t;

    typedef struct packed {
        mem_op_t                op;
        logic [WORD_ADDR_W-1:0] addr;
        logic [15:0]            wdata;
        logic [1:0]             mask;  // Bit 0 low byte, bit 1 high byte
    } mem_req_t;

    typedef struct packed {
        logic [15:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic [BYTE_ADDR_W-1:0] addr;
        logic [7:0]             data;
    } dl_byte_t;

    // Game colour
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb4_t;

    // Output colour
    typedef struct packed {
        logic [5:0] r;
        logic [5:0] g;
        logic [5:0] b;
    } rgb6_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_LOW,
        RD_HIGH,
        RD_DONE
    } rd_state_t;

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_DL,
        OWN_RD
    } arb_owner_t;

endpackage

/* rtl/rom_download.sv */
// One write pending at a time; bytes handed over while downloading is low are discarded
`timescale 1ns/1ps

module rom_download (
    input  logic                clk_sys,
    input  logic                reset,
    input  logic                downloading,
    input  logic                dl_valid,
    input  base_pkg::dl_byte_t  dl_byte,
    output logic                dl_ready,
    output logic                req_valid,
    output base_pkg::mem_req_t  req,
    input  logic                req_ready
);

    logic pend_valid;
    logic take_byte;

    assign dl_ready  = ~pend_valid;  // Stalls the stream while the write waits
    assign take_byte = dl_valid & dl_ready & downloading;
    assign req_valid = pend_valid;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            pend_valid <= 1'b0;
        end else if (take_byte) begin
            pend_valid <= 1'b1;
        end else if (req_valid && req_ready) begin
            pend_valid <= 1'b0;
        end
    end

    // Word write built from the byte, lane picked by the address LSB
    always_ff @(posedge clk_sys) begin
        if (take_byte) begin
            req.op    <= base_pkg::MEM_WRITE;
            req.addr  <= dl_byte.addr[base_pkg::BYTE_ADDR_W-1:1];
            req.wdata <= {dl_byte.data, dl_byte.data};  // Same byte on both lanes
            req.mask  <= dl_byte.addr[0] ? 2'b10 : 2'b01;
        end
    end

endmodule

/* rtl/rom_read_port.sv */
// Reads are refused while downloading is high; a dword takes two memory reads, low word first
`timescale 1ns/1ps

module rom_read_port (
    input  logic                           clk_sys,
    input  logic                           reset,
    input  logic                           downloading,
    input  logic                           rom_req,
    input  logic [base_pkg::ROM_ADDR_W-1:0] rom_addr,
    output logic                           rom_ready,
    output logic [31:0]                    rom_data,
    output logic                           rom_rdy,
    output logic                           req_valid,
    output base_pkg::mem_req_t             req,
    input  logic                           req_ready,
    input  logic                           rsp_valid,
    input  base_pkg::mem_rsp_t             rsp
);

    base_pkg::rd_state_t             state;
    logic                            wait_rsp;  // Word read issued, response not back yet
    logic [base_pkg::ROM_ADDR_W-1:0] addr_q;
    logic [15:0]                     data_lo;
    logic                            busy_rd;

    assign busy_rd   = (state == base_pkg::RD_LOW) || (state == base_pkg::RD_HIGH);
    assign rom_ready = (state == base_pkg::RD_IDLE) & ~downloading;
    assign rom_rdy   = (state == base_pkg::RD_DONE);
    assign req_valid = busy_rd & ~wait_rsp;

    always_comb begin
        req.op    = base_pkg::MEM_READ;
        req.addr  = {addr_q, state == base_pkg::RD_HIGH};  // Odd word for the high half
        req.wdata = '0;
        req.mask  = 2'b11;
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state    <= base_pkg::RD_IDLE;
            wait_rsp <= 1'b0;
        end else begin
            case (state)
                base_pkg::RD_IDLE: begin
                    if (rom_req && rom_ready) state <= base_pkg::RD_LOW;
                end
                base_pkg::RD_LOW, base_pkg::RD_HIGH: begin
                    if (req_valid && req_ready) begin
                        wait_rsp <= 1'b1;
                    end else if (wait_rsp && rsp_valid) begin
                        wait_rsp <= 1'b0;
                        state    <= (state == base_pkg::RD_LOW) ? base_pkg::RD_HIGH
                                                                : base_pkg::RD_DONE;
                    end
                end
                default: state <= base_pkg::RD_IDLE;  // RD_DONE lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rom_req && rom_ready) addr_q <= rom_addr;
        if (wait_rsp && rsp_valid) begin
            if (state == base_pkg::RD_LOW) begin
                data_lo <= rsp.rdata;
            end else begin
                rom_data <= {rsp.rdata, data_lo};
            end
        end
    end

endmodule

/* rtl/mem_arbiter.sv */
// Fixed priority to the download client; only one request in flight, write responses are dropped
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                clk_sys,
    input  logic                reset,
    input  logic                dl_valid,
    input  base_pkg::mem_req_t  dl_req,
    output logic                dl_ready,
    input  logic                rd_valid,
    input  base_pkg::mem_req_t  rd_req,
    output logic                rd_ready,
    output logic                mem_valid,
    output base_pkg::mem_req_t  mem_req,
    input  logic                mem_ready,
    input  logic                mem_rsp_valid,
    input  base_pkg::mem_rsp_t  mem_rsp,
    output logic                rd_rsp_valid,
    output base_pkg::mem_rsp_t  rd_rsp
);

    base_pkg::arb_owner_t owner;
    logic                 idle;
    logic                 take;

    assign idle = (owner == base_pkg::OWN_NONE);

    // Hold off new requests until the outstanding one has answered
    assign mem_valid = (dl_valid | rd_valid) & idle;
    assign mem_req   = dl_valid ? dl_req : rd_req;
    assign take      = mem_valid & mem_ready;

    assign dl_ready = dl_valid & idle & mem_ready;
    assign rd_ready = ~dl_valid & rd_valid & idle & mem_ready;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            owner <= base_pkg::OWN_NONE;
        end else if (mem_rsp_valid) begin
            owner <= base_pkg::OWN_NONE;
        end else if (take) begin
            owner <= dl_valid ? base_pkg::OWN_DL : base_pkg::OWN_RD;
        end
    end

    assign rd_rsp_valid = mem_rsp_valid & (owner == base_pkg::OWN_RD);
    assign rd_rsp       = mem_rsp;

endmodule

/* rtl/rom_mem.sv */
// Behavioural SRAM, no init; every accepted request answers MEM_LATENCY cycles later
`timescale 1ns/1ps

module rom_mem (
    input  logic                clk_sys,
    input  logic                reset,
    input  logic                mem_valid,
    input  base_pkg::mem_req_t  mem_req,
    output logic                mem_ready,
    output logic                mem_rsp_valid,
    output base_pkg::mem_rsp_t  mem_rsp
);

    logic [15:0] mem [0:(2**base_pkg::WORD_ADDR_W)-1];
    logic [base_pkg::MEM_LATENCY-1:0] busy;
    logic [15:0] rdata_q;
    logic        accept;

    assign accept        = mem_valid & mem_ready;
    assign mem_ready     = ~|busy;  // Low until the response cycle is over
    assign mem_rsp_valid = busy[base_pkg::MEM_LATENCY-1];
    assign mem_rsp.rdata = rdata_q;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            busy <= '0;
        end else begin
            busy <= {busy[base_pkg::MEM_LATENCY-2:0], accept};
        end
    end

    always_ff @(posedge clk_sys) begin
        if (accept) begin
            rdata_q <= mem[mem_req.addr];  // Sampled before this cycle's write
            if (mem_req.op == base_pkg::MEM_WRITE) begin
                if (mem_req.mask[0]) mem[mem_req.addr][7:0]  <= mem_req.wdata[7:0];
                if (mem_req.mask[1]) mem[mem_req.addr][15:8] <= mem_req.wdata[15:8];
            end
        end
    end

endmodule

/* rtl/video_out.sv */
// One cycle of delay on every output; composite sync puts CSync on hs and holds vs high
`timescale 1ns/1ps

module video_out (
    input  logic             clk_sys,
    input  logic             reset,
    input  base_pkg::rgb4_t  game_rgb,
    input  logic             hs,
    input  logic             vs,
    input  logic             csync_mode,
    output base_pkg::rgb6_t  vid_rgb,
    output logic             vid_hs,
    output logic             vid_vs
);

    // Repeat the top bits so full scale stays full scale
    function automatic logic [5:0] expand4(input logic [3:0] c);
        return {c, c[3:2]};
    endfunction

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            vid_rgb <= '0;
            vid_hs  <= 1'b0;
            vid_vs  <= 1'b0;
        end else begin
            vid_rgb.r <= expand4(game_rgb.r);
            vid_rgb.g <= expand4(game_rgb.g);
            vid_rgb.b <= expand4(game_rgb.b);
            if (csync_mode) begin
                vid_hs <= ~(hs ^ vs);  // SCART cable wants CSync here
                vid_vs <= 1'b1;        // and VCC to select RGB
            end else begin
                vid_hs <= hs;
                vid_vs <= vs;
            end
        end
    end

endmodule

/* rtl/platform_base.sv */
// Single clock domain on clk_sys; game reads stall while a ROM download is running
`timescale 1ns/1ps

module platform_base (
    input  logic                            clk_sys,
    input  logic                            reset,
    input  logic                            downloading,
    // Download stream
    input  logic                            dl_valid,
    input  base_pkg::dl_byte_t              dl_byte,
    output logic                            dl_ready,
    // Game reads
    input  logic                            rom_req,
    input  logic [base_pkg::ROM_ADDR_W-1:0] rom_addr,
    output logic                            rom_ready,
    output logic [31:0]                     rom_data,
    output logic                            rom_rdy,
    // Video
    input  base_pkg::rgb4_t                 game_rgb,
    input  logic                            hs,
    input  logic                            vs,
    input  logic                            csync_mode,
    output base_pkg::rgb6_t                 vid_rgb,
    output logic                            vid_hs,
    output logic                            vid_vs
);

    base_pkg::mem_req_t dl_mem_req;
    base_pkg::mem_req_t rd_mem_req;
    base_pkg::mem_req_t mem_req;
    base_pkg::mem_rsp_t mem_rsp;
    base_pkg::mem_rsp_t rd_rsp;
    logic               dl_mem_valid;
    logic               dl_mem_ready;
    logic               rd_mem_valid;
    logic               rd_mem_ready;
    logic               mem_valid;
    logic               mem_ready;
    logic               mem_rsp_valid;
    logic               rd_rsp_valid;

    rom_download u_download (
        .clk_sys     ( clk_sys      ),
        .reset       ( reset        ),
        .downloading ( downloading  ),
        .dl_valid    ( dl_valid     ),
        .dl_byte     ( dl_byte      ),
        .dl_ready    ( dl_ready     ),
        .req_valid   ( dl_mem_valid ),
        .req         ( dl_mem_req   ),
        .req_ready   ( dl_mem_ready )
    );

    rom_read_port u_read (
        .clk_sys     ( clk_sys      ),
        .reset       ( reset        ),
        .downloading ( downloading  ),
        .rom_req     ( rom_req      ),
        .rom_addr    ( rom_addr     ),
        .rom_ready   ( rom_ready    ),
        .rom_data    ( rom_data     ),
        .rom_rdy     ( rom_rdy      ),
        .req_valid   ( rd_mem_valid ),
        .req         ( rd_mem_req   ),
        .req_ready   ( rd_mem_ready ),
        .rsp_valid   ( rd_rsp_valid ),
        .rsp         ( rd_rsp       )
    );

    mem_arbiter u_arbiter (
        .clk_sys       ( clk_sys       ),
        .reset         ( reset         ),
        .dl_valid      ( dl_mem_valid  ),
        .dl_req        ( dl_mem_req    ),
        .dl_ready      ( dl_mem_ready  ),
        .rd_valid      ( rd_mem_valid  ),
        .rd_req        ( rd_mem_req    ),
        .rd_ready      ( rd_mem_ready  ),
        .mem_valid     ( mem_valid     ),
        .mem_req       ( mem_req       ),
        .mem_ready     ( mem_ready     ),
        .mem_rsp_valid ( mem_rsp_valid ),
        .mem_rsp       ( mem_rsp       ),
        .rd_rsp_valid  ( rd_rsp_valid  ),
        .rd_rsp        ( rd_rsp        )
    );

    rom_mem u_mem (
        .clk_sys       ( clk_sys       ),
        .reset         ( reset         ),
        .mem_valid     ( mem_valid     ),
        .mem_req       ( mem_req       ),
        .mem_ready     ( mem_ready     ),
        .mem_rsp_valid ( mem_rsp_valid ),
        .mem_rsp       ( mem_rsp       )
    );

    video_out u_video (
        .clk_sys    ( clk_sys    ),
        .reset      ( reset      ),
        .game_rgb   ( game_rgb   ),
        .hs         ( hs         ),
        .vs         ( vs         ),
        .csync_mode ( csync_mode ),
        .vid_rgb    ( vid_rgb    ),
        .vid_hs     ( vid_hs     ),
        .vid_vs     ( vid_vs     )
    );

endmodule

/* tb/platform_base_properties.sv */
// Bound into mem_arbiter; rom_mem timing is checked on the memory port as the arbiter sees it
`timescale 1ns/1ps

module platform_base_properties (
    input logic clk_sys,
    input logic reset,
    input logic mem_valid,
    input logic mem_ready,
    input logic mem_rsp_valid,
    input logic dl_ready,
    input logic rd_ready
);

    int   fail_count = 0;  // Failed assertion count
    logic outstanding;     // Accepted on the memory port, response not seen yet

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            outstanding <= 1'b0;
        end else if (mem_valid && mem_ready) begin
            outstanding <= 1'b1;
        end else if (mem_rsp_valid) begin
            outstanding <= 1'b0;
        end
    end

    // Response exactly MEM_LATENCY cycles after acceptance, and never otherwise
    rsp_latency: assert property (@(posedge clk_sys) disable iff (reset)
        mem_rsp_valid == $past(mem_valid && mem_ready, base_pkg::MEM_LATENCY))
        else begin
            $error("Memory response not %0d cycles after acceptance", base_pkg::MEM_LATENCY);
            fail_count++;
        end

    one_grant: assert property (@(posedge clk_sys) disable iff (reset)
        !(dl_ready && rd_ready))
        else begin
            $error("Download and read clients granted together");
            fail_count++;
        end

    no_overlap: assert property (@(posedge clk_sys) disable iff (reset)
        $rose(mem_valid) |-> !outstanding)
        else begin
            $error("Memory request raised while another is outstanding");
            fail_count++;
        end

endmodule

bind mem_arbiter platform_base_properties u_props (
    .clk_sys       ( clk_sys       ),
    .reset         ( reset         ),
    .mem_valid     ( mem_valid     ),
    .mem_ready     ( mem_ready     ),
    .mem_rsp_valid ( mem_rsp_valid ),
    .dl_ready      ( dl_ready      ),
    .rd_ready      ( rd_ready      )
);

/* tb/tb_platform_base.sv */
// Needs tb/platform_golden.txt relative to the run directory; R lines may only read written dwords
`timescale 1ns/1ps

module tb_platform_base;

    localparam int RESET_CYCLES = 8;

    logic                            clk_sys;
    logic                            reset;
    logic                            downloading;
    logic                            dl_valid;
    base_pkg::dl_byte_t              dl_byte;
    logic                            dl_ready;
    logic                            rom_req;
    logic [base_pkg::ROM_ADDR_W-1:0] rom_addr;
    logic                            rom_ready;
    logic [31:0]                     rom_data;
    logic                            rom_rdy;
    base_pkg::rgb4_t                 game_rgb;
    logic                            hs;
    logic                            vs;
    logic                            csync_mode;
    base_pkg::rgb6_t                 vid_rgb;
    logic                            vid_hs;
    logic                            vid_vs;

    string      lines[$];
    logic [7:0] mirror [0:(2**base_pkg::BYTE_ADDR_W)-1];  // Byte image of what was downloaded
    int         cycles = 0;
    int         cycle_limit = 0;
    int         checks = 0;
    int         mem_errors = 0;
    int         video_errors = 0;
    int         golden_errors = 0;
    int         assert_errors = 0;

    platform_base UUT (.*);

    initial begin
        clk_sys = 1'b0;
        forever #5 clk_sys = ~clk_sys;
    end

    always @(posedge clk_sys) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual, inout int errors);
        checks++;
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic load_golden();
        int    fd;
        string line;
        fd = $fopen("tb/platform_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden vector file tb/platform_golden.txt");
            golden_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") lines.push_back(line);  // Skip comments
            end
            $fclose(fd);
        end
    endtask

    task automatic send_byte(input logic [12:0] addr, input logic [7:0] data);
        @(posedge clk_sys);
        downloading  <= 1'b1;
        dl_valid     <= 1'b1;
        dl_byte.addr <= addr;
        dl_byte.data <= data;
        do @(negedge clk_sys); while (!dl_ready);  // Transfer on the next edge
        @(posedge clk_sys);
        dl_valid <= 1'b0;
        mirror[addr] = data;
        repeat ($urandom_range(3, 0)) @(posedge clk_sys);
    endtask

    task automatic read_dword(input logic [10:0] idx, input logic [31:0] expected);
        string       name;
        logic [12:0] base;
        logic [31:0] model;
        name  = $sformatf("read %03h", idx);
        base  = {idx, 2'b00};
        model = {mirror[base + 13'd3], mirror[base + 13'd2], mirror[base + 13'd1], mirror[base]};
        check_value({name, " golden vs mirror"}, expected, model, golden_errors);
        @(posedge clk_sys);
        rom_req  <= 1'b1;
        rom_addr <= idx;
        if (downloading) begin
            // Request must sit blocked while the download runs
            repeat (4) begin
                @(negedge clk_sys);
                check_value({name, " rom_ready during download"}, 32'd0, 32'(rom_ready),
                            mem_errors);
                check_value({name, " rom_rdy during download"}, 32'd0, 32'(rom_rdy), mem_errors);
            end
            @(posedge clk_sys);
            downloading <= 1'b0;
        end
        do @(negedge clk_sys); while (!rom_ready);
        @(posedge clk_sys);
        rom_req <= 1'b0;
        do @(negedge clk_sys); while (!rom_rdy);
        check_value(name, expected, rom_data, mem_errors);
    endtask

    task automatic check_video(input logic [31:0] rgb, input logic [31:0] h, input logic [31:0] v,
                               input logic [31:0] mode, input logic [31:0] exp_rgb,
                               input logic [31:0] exp_hs, input logic [31:0] exp_vs);
        string name;
        name = $sformatf("video %03h mode %0d", rgb[11:0], mode[0]);
        @(posedge clk_sys);
        game_rgb   <= rgb[11:0];
        hs         <= h[0];
        vs         <= v[0];
        csync_mode <= mode[0];
        @(posedge clk_sys);  // Sampled by the DUT here
        @(negedge clk_sys);
        check_value({name, " rgb"}, exp_rgb, 32'(vid_rgb), video_errors);
        check_value({name, " hs"}, exp_hs, 32'(vid_hs), video_errors);
        check_value({name, " vs"}, exp_vs, 32'(vid_vs), video_errors);
    endtask

    initial begin
        string       line;
        logic [31:0] f [0:6];
        void'($urandom(32'hc865a7ac));
        reset       = 1'b1;
        downloading = 1'b0;
        dl_valid    = 1'b0;
        dl_byte     = '0;
        rom_req     = 1'b0;
        rom_addr    = '0;
        game_rgb    = '0;
        hs          = 1'b0;
        vs          = 1'b0;
        csync_mode  = 1'b0;
        load_golden();
        cycle_limit = lines.size() * 40 + 200;
        repeat (RESET_CYCLES) @(posedge clk_sys);
        reset <= 1'b0;
        @(negedge clk_sys);
        check_value("reset rom_rdy", 32'd0, 32'(rom_rdy), mem_errors);
        check_value("reset video", 32'd0, 32'({vid_rgb, vid_hs, vid_vs}), video_errors);
        check_value("reset dl_ready", 32'd1, 32'(dl_ready), mem_errors);
        check_value("reset rom_ready", 32'd1, 32'(rom_ready), mem_errors);
        foreach (lines[i]) begin
            line = lines[i];
            case (line[0])
                "W": begin
                    void'($sscanf(line, "W %h %h", f[0], f[1]));
                    send_byte(f[0][12:0], f[1][7:0]);
                end
                "R": begin
                    void'($sscanf(line, "R %h %h", f[0], f[1]));
                    read_dword(f[0][10:0], f[1]);
                end
                "V": begin
                    void'($sscanf(line, "V %h %h %h %h %h %h %h",
                                  f[0], f[1], f[2], f[3], f[4], f[5], f[6]));
                    check_video(f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
                end
                default: begin
                    $display("Unknown line in the golden file: %s", line);
                    golden_errors++;
                end
            endcase
        end
        repeat (4) @(posedge clk_sys);
        assert_errors = UUT.u_arbiter.u_props.fail_count;
        $display("Checks %0d, errors: memory %0d, video %0d, golden %0d, assertions %0d",
                 checks, mem_errors, video_errors, golden_errors, assert_errors);
        if (mem_errors + video_errors + golden_errors + assert_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* tb/platform_golden.txt */
# W byte_addr byte | R dword_index expected_dword | all values hex
# V rgb444 hs vs csync_mode expected_rgb666 expected_hs expected_vs
W 0010 11
W 0011 22
W 0012 33
W 0013 44
W 0014 55
W 0015 66
W 0016 77
W 0017 88
R 004 44332211
R 005 88776655
W 0011 a5
R 004 4433a511
R 005 88776655
W 1ffc de
W 1ffd ad
W 1ffe be
W 1fff ef
R 7ff efbeadde
V f00 1 0 0 3f000 1 0
V 0f0 0 1 0 00fc0 0 1
V 00f 1 1 0 0003f 1 1
V 8c4 0 0 0 22cd1 0 0
V 123 0 0 1 0420c 1 1
V fff 1 0 1 3ffff 0 1
V a5e 0 1 1 2a57b 0 1
V 777 1 1 1 1d75d 1 1

/* tb.f */
rtl/base_pkg.sv
rtl/rom_download.sv
rtl/rom_read_port.sv
rtl/mem_arbiter.sv
rtl/rom_mem.sv
rtl/video_out.sv
rtl/platform_base.sv
tb/platform_base_properties.sv
tb/tb_platform_base.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_platform_base -Mdir obj_dir

./obj_dir/Vtb_platform_base +verilator+error+limit+100 | tee sim.log

grep -q "All tests passed" sim.log
echo "Simulation passed"
